// ==== design/mvb_fifo_pkg.sv ====
// ======================================================================
// Shared sizes and vector types of the dual-clock MVB FIFO
// Entry layout in memory is {vld, data}, mask in the upper bits
// DEPTH_LOG sets a power-of-two memory depth only
// ======================================================================
`default_nettype none

package mvb_fifo_pkg;

    // Bus geometry
    localparam int ITEMS      = 4;
    localparam int ITEM_WIDTH = 16;
    localparam int DATA_WIDTH = ITEMS * ITEM_WIDTH;

    // Stored entry holds data plus the item mask
    localparam int ENTRY_WIDTH = DATA_WIDTH + ITEMS;

    // Memory depth in words
    localparam int DEPTH_LOG = 4;
    localparam int DEPTH     = 1 << DEPTH_LOG;

    // Extra wrap bit tells full from empty
    localparam int PTR_WIDTH = DEPTH_LOG + 1;

    // One bus word of item data
    typedef logic [DATA_WIDTH-1:0] data_t;

    // Per-item valid mask
    typedef logic [ITEMS-1:0] vld_t;

    // Memory entry
    typedef logic [ENTRY_WIDTH-1:0] entry_t;

    // Memory address
    typedef logic [DEPTH_LOG-1:0] addr_t;

    // FIFO pointer, address plus wrap bit
    typedef logic [PTR_WIDTH-1:0] ptr_t;

endpackage

`default_nettype wire

// ==== design/mvb_fifo_ram.sv ====
// ======================================================================
// Simple dual-port memory, write on wr_clk, registered read on rd_clk
// Read data appears one rd_clk cycle after re and holds while re low
// No reset, contents are undefined until written
// ======================================================================
`timescale 1ns/10ps
`default_nettype none

module mvb_fifo_ram (
    // Write port
    input  logic                 wr_clk,
    input  logic                 we,
    input  mvb_fifo_pkg::addr_t  waddr,
    input  mvb_fifo_pkg::entry_t wdata,

    // Read port
    input  logic                 rd_clk,
    input  logic                 re,
    input  mvb_fifo_pkg::addr_t  raddr,
    output mvb_fifo_pkg::entry_t rdata
);
    import mvb_fifo_pkg::*;

    // Storage array
    entry_t mem [DEPTH];

    // Write side
    always_ff @(posedge wr_clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Registered read
    // Output keeps the last word while no read is issued
    always_ff @(posedge rd_clk) begin
        if (re) begin
            rdata <= mem[raddr];
        end
    end

endmodule

`default_nettype wire

// ==== design/mvb_ptr_cdc.sv ====
// ======================================================================
// Pointer crossing: binary -> Gray, two-flop sync, Gray -> binary
// Input must step by at most one per src_clk edge
// Latency is one src_clk edge plus two dst_clk edges
// ======================================================================
`timescale 1ns/10ps
`default_nettype none

module mvb_ptr_cdc (
    input  logic               src_clk,
    input  logic               dst_clk,
    input  logic               rst_n,
    input  mvb_fifo_pkg::ptr_t ptr,
    output mvb_fifo_pkg::ptr_t ptr_sync
);
    import mvb_fifo_pkg::*;

    // Gray code, registered in the source domain
    ptr_t gray_q;

    // Destination synchronizer stages
    ptr_t sync_q1;
    ptr_t sync_q2;

    // Register Gray so only one bit moves per pointer step
    // and no combinational glitch reaches the crossing
    always_ff @(posedge src_clk or negedge rst_n) begin
        if (!rst_n) begin
            gray_q <= '0;
        end else begin
            gray_q <= ptr ^ (ptr >> 1);
        end
    end

    // Two flops in the destination domain
    always_ff @(posedge dst_clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
        end else begin
            sync_q1 <= gray_q;
            sync_q2 <= sync_q1;
        end
    end

    // Back to binary
    // Each bit is the XOR of all Gray bits at or above it
    always_comb begin
        for (int i = 0; i < PTR_WIDTH; i++) begin
            ptr_sync[i] = ^(sync_q2 >> i);
        end
    end

endmodule

`default_nettype wire

// ==== design/mvb_fifo_wr_ctrl.sv ====
// ======================================================================
// Write side control in the rx_clk domain
// Words with an all-zero mask are accepted and dropped
// rd_ptr_sync lags the true read pointer, so full is conservative
// ======================================================================
`timescale 1ns/10ps
`default_nettype none

module mvb_fifo_wr_ctrl (
    input  logic                 rx_clk,
    input  logic                 rst_n,

    // MVB write port
    input  mvb_fifo_pkg::data_t  rx_data,
    input  mvb_fifo_pkg::vld_t   rx_vld,
    input  logic                 rx_src_rdy,
    output logic                 rx_dst_rdy,

    // Pointers
    input  mvb_fifo_pkg::ptr_t   rd_ptr_sync,
    output mvb_fifo_pkg::ptr_t   wr_ptr,

    // Memory write port
    output logic                 ram_we,
    output mvb_fifo_pkg::addr_t  ram_waddr,
    output mvb_fifo_pkg::entry_t ram_wdata
);
    import mvb_fifo_pkg::*;

    // Set on the first rx_clk edge after reset release
    logic rst_done_q;

    // Occupancy as seen from the write side
    ptr_t fill;
    logic full;

    // Handshake and store qualifiers
    logic xfer;
    logic has_item;

    always_ff @(posedge rx_clk or negedge rst_n) begin
        if (!rst_n) begin
            rst_done_q <= 1'b0;
        end else begin
            rst_done_q <= 1'b1;
        end
    end

    // Pointer difference wraps mod 2*DEPTH
    assign fill = wr_ptr - rd_ptr_sync;
    assign full = (fill == ptr_t'(DEPTH));

    // Ready is independent of rx_src_rdy
    assign rx_dst_rdy = rst_done_q && !full;

    assign xfer     = rx_src_rdy && rx_dst_rdy;
    assign has_item = |rx_vld;

    // Only words with at least one valid item are stored
    assign ram_we    = xfer && has_item;
    assign ram_waddr = wr_ptr[DEPTH_LOG-1:0];
    assign ram_wdata = {rx_vld, rx_data};

    // Pointer moves on the same edge that writes the word
    always_ff @(posedge rx_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (ram_we) begin
            wr_ptr <= wr_ptr + ptr_t'(1);
        end
    end

endmodule

`default_nettype wire

// ==== design/mvb_fifo_rd_ctrl.sv ====
// ======================================================================
// Read side control in the tx_clk domain
// One output register loaded on the cycle after each RAM read
// tx_data and tx_vld hold while tx_src_rdy is high and tx_dst_rdy low
// ======================================================================
`timescale 1ns/10ps
`default_nettype none

module mvb_fifo_rd_ctrl (
    input  logic                 tx_clk,
    input  logic                 rst_n,

    // MVB read port
    output mvb_fifo_pkg::data_t  tx_data,
    output mvb_fifo_pkg::vld_t   tx_vld,
    output logic                 tx_src_rdy,
    input  logic                 tx_dst_rdy,

    // Pointers
    input  mvb_fifo_pkg::ptr_t   wr_ptr_sync,
    output mvb_fifo_pkg::ptr_t   rd_ptr,

    // Memory read port
    output logic                 ram_re,
    output mvb_fifo_pkg::addr_t  ram_raddr,
    input  mvb_fifo_pkg::entry_t ram_rdata
);
    import mvb_fifo_pkg::*;

    // Output register holds a word
    logic out_full_q;

    // Read data valid on ram_rdata this cycle
    logic rd_pend_q;

    // Per-cycle events
    logic pop;
    logic has_data;
    logic load;

    assign tx_src_rdy = out_full_q;
    assign pop        = out_full_q && tx_dst_rdy;

    // Memory holds unread words
    assign has_data = (rd_ptr != wr_ptr_sync);

    // Prefetch when the register is free with nothing in flight,
    // or when it drains this cycle
    assign ram_re    = has_data && ((!out_full_q && !rd_pend_q) || pop);
    assign ram_raddr = rd_ptr[DEPTH_LOG-1:0];

    // Register is always free when the read data lands
    assign load = rd_pend_q;

    always_ff @(posedge tx_clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (ram_re) begin
            rd_ptr <= rd_ptr + ptr_t'(1);
        end
    end

    // Pending flag
    // High for the one cycle after each read
    always_ff @(posedge tx_clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_pend_q <= 1'b0;
        end else begin
            rd_pend_q <= ram_re;
        end
    end

    // Output valid flag
    always_ff @(posedge tx_clk or negedge rst_n) begin
        if (!rst_n) begin
            out_full_q <= 1'b0;
        end else if (load) begin
            out_full_q <= 1'b1;
        end else if (pop) begin
            out_full_q <= 1'b0;
        end
    end

    // Output payload
    always_ff @(posedge tx_clk) begin
        if (load) begin
            tx_vld  <= ram_rdata[DATA_WIDTH +: ITEMS];
            tx_data <= ram_rdata[DATA_WIDTH-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== design/mvb_async_fifo.sv ====
// ======================================================================
// Dual-clock MVB FIFO, rx_clk write side and tx_clk read side
// rst_n clears both domains, assert it long enough for both clocks
// Settled capacity is DEPTH words plus the output register
// ======================================================================
`timescale 1ns/10ps
`default_nettype none

module mvb_async_fifo (
    input  logic                rx_clk,
    input  logic                tx_clk,
    input  logic                rst_n,

    // Write port, rx_clk
    input  mvb_fifo_pkg::data_t rx_data,
    input  mvb_fifo_pkg::vld_t  rx_vld,
    input  logic                rx_src_rdy,
    output logic                rx_dst_rdy,

    // Read port, tx_clk
    output mvb_fifo_pkg::data_t tx_data,
    output mvb_fifo_pkg::vld_t  tx_vld,
    output logic                tx_src_rdy,
    input  logic                tx_dst_rdy
);
    import mvb_fifo_pkg::*;

    // Binary pointers and their synchronized copies
    ptr_t wr_ptr;
    ptr_t wr_ptr_sync;
    ptr_t rd_ptr;
    ptr_t rd_ptr_sync;

    // Memory ports
    logic   ram_we;
    addr_t  ram_waddr;
    entry_t ram_wdata;
    logic   ram_re;
    addr_t  ram_raddr;
    entry_t ram_rdata;

    mvb_fifo_wr_ctrl i_wr_ctrl (
        .rx_clk      (rx_clk),
        .rst_n       (rst_n),
        .rx_data     (rx_data),
        .rx_vld      (rx_vld),
        .rx_src_rdy  (rx_src_rdy),
        .rx_dst_rdy  (rx_dst_rdy),
        .rd_ptr_sync (rd_ptr_sync),
        .wr_ptr      (wr_ptr),
        .ram_we      (ram_we),
        .ram_waddr   (ram_waddr),
        .ram_wdata   (ram_wdata)
    );

    // Write pointer into the read domain
    mvb_ptr_cdc i_wr_ptr_cdc (
        .src_clk  (rx_clk),
        .dst_clk  (tx_clk),
        .rst_n    (rst_n),
        .ptr      (wr_ptr),
        .ptr_sync (wr_ptr_sync)
    );

    // Read pointer into the write domain
    mvb_ptr_cdc i_rd_ptr_cdc (
        .src_clk  (tx_clk),
        .dst_clk  (rx_clk),
        .rst_n    (rst_n),
        .ptr      (rd_ptr),
        .ptr_sync (rd_ptr_sync)
    );

    mvb_fifo_ram i_ram (
        .wr_clk (rx_clk),
        .we     (ram_we),
        .waddr  (ram_waddr),
        .wdata  (ram_wdata),
        .rd_clk (tx_clk),
        .re     (ram_re),
        .raddr  (ram_raddr),
        .rdata  (ram_rdata)
    );

    mvb_fifo_rd_ctrl i_rd_ctrl (
        .tx_clk      (tx_clk),
        .rst_n       (rst_n),
        .tx_data     (tx_data),
        .tx_vld      (tx_vld),
        .tx_src_rdy  (tx_src_rdy),
        .tx_dst_rdy  (tx_dst_rdy),
        .wr_ptr_sync (wr_ptr_sync),
        .rd_ptr      (rd_ptr),
        .ram_re      (ram_re),
        .ram_raddr   (ram_raddr),
        .ram_rdata   (ram_rdata)
    );

endmodule

`default_nettype wire

// ==== bench/tb_mvb_async_fifo.sv ====
// ======================================================================
// Self-checking bench for the dual-clock MVB FIFO with a queue model
// Uses 64-bit data words, so it expects ITEMS*ITEM_WIDTH of 64
// Full test expects DEPTH words plus one in the output register
// ======================================================================
`timescale 1ns/10ps
`default_nettype none

module tb_mvb_async_fifo;
    import mvb_fifo_pkg::*;

    // Run setup
    localparam logic [31:0] SEED = 32'h790f;
    localparam int RX_HALF      = 20;
    localparam int TX_HALF      = 20;
    localparam int TX_PHASE     = 13;
    localparam int RESET_CYCLES = 5;

    // Test lengths
    localparam int N_ORDERED     = 300;
    localparam int N_DISCARD     = 200;
    localparam int N_BACKPRESS   = 400;
    localparam int FULL_WORDS    = DEPTH + 1;
    localparam int FILL_SETTLE   = 40;
    localparam int IDLE_CYCLES   = 50;
    localparam int TOTAL_WORDS   = N_ORDERED + N_DISCARD + FULL_WORDS + N_BACKPRESS;
    localparam int TIMEOUT_LIMIT = TOTAL_WORDS * 12 + 2000;

    logic  rx_clk;
    logic  tx_clk;
    logic  rst_n;
    data_t rx_data;
    vld_t  rx_vld;
    logic  rx_src_rdy;
    logic  rx_dst_rdy;
    data_t tx_data;
    vld_t  tx_vld;
    logic  tx_src_rdy;
    logic  tx_dst_rdy;

    // Model of stored words, in write order
    entry_t model_q[$];

    int   errors;
    int   err_mark;
    int   words_checked;
    logic wr_done;
    logic ready_seen;
    bit   tx_started = 1'b0;

    mvb_async_fifo i_dut (
        .rx_clk     (rx_clk),
        .tx_clk     (tx_clk),
        .rst_n      (rst_n),
        .rx_data    (rx_data),
        .rx_vld     (rx_vld),
        .rx_src_rdy (rx_src_rdy),
        .rx_dst_rdy (rx_dst_rdy),
        .tx_data    (tx_data),
        .tx_vld     (tx_vld),
        .tx_src_rdy (tx_src_rdy),
        .tx_dst_rdy (tx_dst_rdy)
    );

    initial rx_clk = 1'b0;
    always #(RX_HALF) rx_clk = ~rx_clk;

    // tx_clk lags by TX_PHASE so no edges of the two domains coincide
    always begin
        if (!tx_started) begin
            tx_clk = 1'b0;
            #(TX_PHASE);
            tx_started = 1'b1;
        end
        #(TX_HALF) tx_clk = ~tx_clk;
    end

    task automatic report_mismatch(input string sig, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("CHECK FAILED %s expected 0x%0h actual 0x%0h at %0t",
                 sig, expected, actual, $time);
        errors++;
    endtask

    task automatic report_error(input string msg);
        $display("ERROR %s at %0t", msg, $time);
        errors++;
    endtask

    task automatic begin_test();
        err_mark = errors;
        wr_done  = 1'b0;
    endtask

    task automatic end_test(input int num, input string name);
        $display("test %0d %s done, %0d errors", num, name, errors - err_mark);
    endtask

    // Random word, mask all zero with probability zero_pct
    task automatic drive_word(input int zero_pct);
        vld_t vld;
        if (int'($urandom % 100) < zero_pct) begin
            vld = '0;
        end else begin
            do begin
                vld = vld_t'($urandom);
            end while (vld == '0);
        end
        rx_vld  <= vld;
        rx_data <= {$urandom, $urandom};
    endtask

    // Writer, n counts accepted words including dropped ones
    task automatic write_words(input int n, input int src_pct, input int zero_pct);
        int accepted;
        accepted = 0;
        while (accepted < n) begin
            @(posedge rx_clk);
            if (int'($urandom % 100) < src_pct) begin
                drive_word(zero_pct);
                rx_src_rdy <= 1'b1;
            end else begin
                rx_src_rdy <= 1'b0;
            end
            // Handshake seen here commits on the next rising edge
            @(negedge rx_clk);
            if (rx_src_rdy && rx_dst_rdy) begin
                if (rx_vld != '0) begin
                    model_q.push_back({rx_vld, rx_data});
                end
                accepted++;
            end
        end
        @(posedge rx_clk);
        rx_src_rdy <= 1'b0;
        wr_done = 1'b1;
    endtask

    // Reader, runs until the writer is done and the model is drained
    task automatic read_words(input int dst_pct);
        entry_t expected;
        entry_t held;
        logic   stalled;
        stalled = 1'b0;
        held    = '0;
        while (!(wr_done && model_q.size() == 0)) begin
            @(posedge tx_clk);
            tx_dst_rdy <= (int'($urandom % 100) < dst_pct);
            @(negedge tx_clk);
            // Stalled word must not move
            if (stalled) begin
                if (!tx_src_rdy) begin
                    report_error("tx_src_rdy dropped while the word was stalled");
                end
                if (tx_data !== held[DATA_WIDTH-1:0]) begin
                    report_mismatch("tx_data", held[DATA_WIDTH-1:0], tx_data);
                end
                if (tx_vld !== held[DATA_WIDTH +: ITEMS]) begin
                    report_mismatch("tx_vld", 64'(held[DATA_WIDTH +: ITEMS]), 64'(tx_vld));
                end
            end
            stalled = tx_src_rdy && !tx_dst_rdy;
            held    = {tx_vld, tx_data};
            if (tx_src_rdy && tx_dst_rdy) begin
                if (model_q.size() == 0) begin
                    report_error("output word with no word left in the model");
                end else begin
                    expected = model_q.pop_front();
                    if (tx_data !== expected[DATA_WIDTH-1:0]) begin
                        report_mismatch("tx_data", expected[DATA_WIDTH-1:0], tx_data);
                    end
                    if (tx_vld !== expected[DATA_WIDTH +: ITEMS]) begin
                        report_mismatch("tx_vld", 64'(expected[DATA_WIDTH +: ITEMS]),
                                        64'(tx_vld));
                    end
                    words_checked++;
                end
            end
        end
        @(posedge tx_clk);
        tx_dst_rdy <= 1'b0;
    endtask

    // Source always ready, sink blocked, count what the write side takes
    task automatic fill_while_blocked();
        int accepted;
        accepted = 0;
        repeat (FILL_SETTLE) begin
            @(posedge rx_clk);
            drive_word(0);
            rx_src_rdy <= 1'b1;
            @(negedge rx_clk);
            if (rx_src_rdy && rx_dst_rdy) begin
                model_q.push_back({rx_vld, rx_data});
                accepted++;
            end
        end
        @(posedge rx_clk);
        rx_src_rdy <= 1'b0;
        @(negedge rx_clk);
        if (accepted != FULL_WORDS) begin
            report_mismatch("accepted words", 64'(FULL_WORDS), 64'(accepted));
        end
        if (rx_dst_rdy !== 1'b0) begin
            report_mismatch("rx_dst_rdy", 64'(0), 64'(rx_dst_rdy));
        end
        wr_done = 1'b1;
    endtask

    // No output may appear without writes
    task automatic check_idle_output(input int cycles);
        repeat (cycles) begin
            @(negedge tx_clk);
            if (tx_src_rdy !== 1'b0) begin
                report_mismatch("tx_src_rdy", 64'(0), 64'(tx_src_rdy));
            end
        end
    endtask

    initial begin
        rst_n      <= 1'b0;
        rx_data    <= '0;
        rx_vld     <= '0;
        rx_src_rdy <= 1'b0;
        tx_dst_rdy <= 1'b0;
        errors        = 0;
        err_mark      = 0;
        words_checked = 0;
        wr_done       = 1'b0;
        ready_seen    = 1'b0;
        void'($urandom(SEED));

        // Reset state
        begin_test();
        repeat (RESET_CYCLES) begin
            @(negedge rx_clk);
            if (rx_dst_rdy !== 1'b0) begin
                report_mismatch("rx_dst_rdy", 64'(0), 64'(rx_dst_rdy));
            end
            if (tx_src_rdy !== 1'b0) begin
                report_mismatch("tx_src_rdy", 64'(0), 64'(tx_src_rdy));
            end
        end
        @(posedge rx_clk);
        rst_n <= 1'b1;
        @(negedge tx_clk);
        if (tx_src_rdy !== 1'b0) begin
            report_mismatch("tx_src_rdy", 64'(0), 64'(tx_src_rdy));
        end
        repeat (2) begin
            @(negedge rx_clk);
            if (rx_dst_rdy) begin
                ready_seen = 1'b1;
            end
        end
        if (!ready_seen) begin
            report_error("rx_dst_rdy not high within two rx_clk cycles of reset release");
        end
        end_test(1, "reset state");

        // Both sides always ready
        begin_test();
        fork
            write_words(N_ORDERED, 100, 0);
            read_words(100);
        join
        end_test(2, "ordered transfer");

        // Empty masks mixed in
        begin_test();
        fork
            write_words(N_DISCARD, 100, 30);
            read_words(100);
        join
        end_test(3, "discard");

        // Fill with the sink blocked, then drain
        begin_test();
        fill_while_blocked();
        read_words(100);
        end_test(4, "full");

        begin_test();
        check_idle_output(IDLE_CYCLES);
        end_test(5, "empty");

        // Random stalls on both sides
        begin_test();
        fork
            write_words(N_BACKPRESS, 60, 20);
            read_words(60);
        join
        end_test(6, "random back-pressure");

        $display("tests: 6, words checked: %0d, errors: %0d", words_checked, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Watchdog on rx_clk cycles
    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_LIMIT) begin
            @(posedge rx_clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d rx_clk cycles", TIMEOUT_LIMIT);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
design/mvb_fifo_pkg.sv
design/mvb_fifo_ram.sv
design/mvb_ptr_cdc.sv
design/mvb_fifo_wr_ctrl.sv
design/mvb_fifo_rd_ctrl.sv
design/mvb_async_fifo.sv
bench/tb_mvb_async_fifo.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the dual-clock MVB FIFO bench with Verilator.
# Exits with a failing status unless the bench reports a pass.
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    --timescale 1ns/10ps \
    --top-module tb_mvb_async_fifo \
    -Mdir obj_dir \
    -f tb.f

out=$(./obj_dir/Vtb_mvb_async_fifo)
echo "$out"

if echo "$out" | grep -qx '>>> PASS'; then
    exit 0
else
    exit 1
fi
